// ==== id_macros.svh ====
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// ==================================================
// datapath sizes
// ==================================================
`define ID_XLEN        32   // data and pc width
`define ID_REG_AW      5    // register address width
`define ID_REG_NUM     32   // architectural registers x0..x31

// ==================================================
// flow control
// ==================================================
// fetch side starts with one credit per buffer slot
`define ID_IN_DEPTH    4
// issue slots granted by execute after reset
`define ID_EX_CREDITS  2
// wide enough for 0..ID_IN_DEPTH and 0..ID_EX_CREDITS
`define ID_CNT_W       3

`endif

// ==== id_pkg.sv ====
`include "id_macros.svh"

package id_pkg;

    // ==================================================
    // encodings
    // ==================================================
    // operation class handed to execute
    typedef enum logic [3:0] {
        OP_ALU_R   = 4'd0,
        OP_ALU_I   = 4'd1,
        OP_LOAD    = 4'd2,
        OP_STORE   = 4'd3,
        OP_BRANCH  = 4'd4,
        OP_LUI     = 4'd5,
        OP_AUIPC   = 4'd6,
        OP_JAL     = 4'd7,
        OP_JALR    = 4'd8,
        OP_ILLEGAL = 4'd9
    } id_op_e;

    // rv32i major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } rv_opc_e;

    // ==================================================
    // bundles
    // ==================================================
    typedef struct packed {
        logic [`ID_XLEN-1:0]   instr;
        logic [`ID_XLEN-1:0]   pc;
    } fetch_pkt_t;

    typedef struct packed {
        id_op_e                op;
        logic [`ID_REG_AW-1:0] rs1;       // zero when not read
        logic [`ID_REG_AW-1:0] rs2;       // zero when not read
        logic [`ID_REG_AW-1:0] rd;        // zero when not written
        logic                  rd_we;
        logic [2:0]            funct3;
        logic                  funct7_b5; // sub/sra select
        logic [`ID_XLEN-1:0]   imm;       // sign extended
    } dec_t;

    typedef struct packed {
        logic                  we;
        logic [`ID_REG_AW-1:0] addr;
        logic [`ID_XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        dec_t                  dec;
        logic [`ID_XLEN-1:0]   pc;
        logic [`ID_XLEN-1:0]   rs1_val;
        logic [`ID_XLEN-1:0]   rs2_val;
    } issue_t;

endpackage

// ==== id_in_buffer.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module id_in_buffer (
    input  logic               clk_i,
    input  logic               resetn_i,
    input  logic               push_i,
    input  id_pkg::fetch_pkt_t push_data_i,
    input  logic               pop_i,
    output id_pkg::fetch_pkt_t head_o,
    output logic               not_empty_o,
    output logic               credit_o     // one pulse per pop
);
    import id_pkg::*;

    localparam int PTR_W = $clog2(`ID_IN_DEPTH);

    fetch_pkt_t            mem [`ID_IN_DEPTH]; // payload only, no reset
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [`ID_CNT_W-1:0]  count;
    logic                  full;

    assign full        = (count == `ID_CNT_W'(`ID_IN_DEPTH));
    assign not_empty_o = (count != '0);
    assign head_o      = mem[rd_ptr]; // head visible to decode same cycle

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // pointers wrap explicitly, depth need not be a power of two
    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(`ID_IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(`ID_IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither
            endcase
            credit_o <= pop_i;               // slot freed, hand credit back
        end
    end

    // ==================================================
    // protocol checks
    // ==================================================
    // sender pushing at full has spent a credit it never had
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!resetn_i)
        push_i |-> !full)
        else $error("id_in_buffer: push while full");

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!resetn_i)
        pop_i |-> not_empty_o)
        else $error("id_in_buffer: pop while empty");

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module instr_decoder (
    input  logic [`ID_XLEN-1:0] instr_i,
    output id_pkg::dec_t        dec_o
);
    import id_pkg::*;

    logic [6:0]            opcode;
    logic [`ID_REG_AW-1:0] f_rd;
    logic [`ID_REG_AW-1:0] f_rs1;
    logic [`ID_REG_AW-1:0] f_rs2;
    logic [`ID_XLEN-1:0]   imm_i;
    logic [`ID_XLEN-1:0]   imm_s;
    logic [`ID_XLEN-1:0]   imm_b;
    logic [`ID_XLEN-1:0]   imm_u;
    logic [`ID_XLEN-1:0]   imm_j;

    // ==================================================
    // raw fields
    // ==================================================
    assign opcode = instr_i[6:0];
    assign f_rd   = instr_i[11:7];
    assign f_rs1  = instr_i[19:15];
    assign f_rs2  = instr_i[24:20];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};   // bit 0 implied
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    // ==================================================
    // class, register usage, immediate select
    // ==================================================
    always_comb begin
        // defaults describe an illegal word, no reads and no write
        dec_o           = '0;
        dec_o.op        = OP_ILLEGAL;
        dec_o.funct3    = instr_i[14:12];
        dec_o.funct7_b5 = instr_i[30];

        case (opcode)
            OPC_OP: begin
                dec_o.op  = OP_ALU_R;
                dec_o.rs1 = f_rs1;
                dec_o.rs2 = f_rs2;
                dec_o.rd  = f_rd;
            end
            OPC_OP_IMM: begin
                dec_o.op  = OP_ALU_I;
                dec_o.rs1 = f_rs1;
                dec_o.rd  = f_rd;
                dec_o.imm = imm_i;     // shamt sits in imm[4:0]
            end
            OPC_LOAD: begin
                dec_o.op  = OP_LOAD;
                dec_o.rs1 = f_rs1;
                dec_o.rd  = f_rd;
                dec_o.imm = imm_i;
            end
            OPC_STORE: begin
                dec_o.op  = OP_STORE;
                dec_o.rs1 = f_rs1;     // base
                dec_o.rs2 = f_rs2;     // store data
                dec_o.imm = imm_s;
            end
            OPC_BRANCH: begin
                dec_o.op  = OP_BRANCH;
                dec_o.rs1 = f_rs1;
                dec_o.rs2 = f_rs2;
                dec_o.imm = imm_b;
            end
            OPC_LUI: begin
                dec_o.op  = OP_LUI;
                dec_o.rd  = f_rd;
                dec_o.imm = imm_u;
            end
            OPC_AUIPC: begin
                dec_o.op  = OP_AUIPC;
                dec_o.rd  = f_rd;
                dec_o.imm = imm_u;
            end
            OPC_JAL: begin
                dec_o.op  = OP_JAL;
                dec_o.rd  = f_rd;      // link register
                dec_o.imm = imm_j;
            end
            OPC_JALR: begin
                dec_o.op  = OP_JALR;
                dec_o.rs1 = f_rs1;
                dec_o.rd  = f_rd;
                dec_o.imm = imm_i;
            end
            default: ;                 // fence, system, csr, junk
        endcase

        // store, branch, illegal never write back
        dec_o.rd_we = !(dec_o.op inside {OP_STORE, OP_BRANCH, OP_ILLEGAL});
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile #(
    parameter int REG_DATA_WIDTH     = 32,
    parameter int REGFILE_ADDR_WIDTH = 5,
    parameter int REGFILE_DEPTH      = 32
) (
    input  logic                          clk_i,
    input  logic                          resetn_i,
    input  logic [REGFILE_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [REGFILE_ADDR_WIDTH-1:0] rs2_addr_i,
    output logic [REG_DATA_WIDTH-1:0]     rs1_data_o,
    output logic [REG_DATA_WIDTH-1:0]     rs2_data_o,
    input  id_pkg::wb_t                   wb_i        // no handshake, used as presented
);

    logic [REG_DATA_WIDTH-1:0] regs [REGFILE_DEPTH];
    logic                      wr_en;
    logic                      byp1;
    logic                      byp2;

    assign wr_en = wb_i.we && (wb_i.addr != '0);   // x0 writes dropped

    // ==================================================
    // write port
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            for (int i = 0; i < REGFILE_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // ==================================================
    // read ports
    // ==================================================
    // same-cycle writeback wins over stored value
    assign byp1 = wr_en && (rs1_addr_i == wb_i.addr);
    assign byp2 = wr_en && (rs2_addr_i == wb_i.addr);

    assign rs1_data_o = byp1 ? wb_i.data : regs[rs1_addr_i];
    assign rs2_data_o = byp2 ? wb_i.data : regs[rs2_addr_i];

    // x0 must hold zero across every write pattern
    a_x0_zero: assert property (@(posedge clk_i) disable iff (!resetn_i)
        regs[0] == '0)
        else $error("regfile: x0 not zero");

endmodule

// ==== id_issue_ctrl.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module id_issue_ctrl (
    input  logic                  clk_i,
    input  logic                  resetn_i,
    input  logic                  not_empty_i,
    input  id_pkg::fetch_pkt_t    head_i,
    input  id_pkg::dec_t          dec_i,
    output logic [`ID_REG_AW-1:0] rs1_addr_o,
    output logic [`ID_REG_AW-1:0] rs2_addr_o,
    input  logic [`ID_XLEN-1:0]   rs1_data_i,
    input  logic [`ID_XLEN-1:0]   rs2_data_i,
    output logic                  pop_o,
    input  logic                  ex_credit_i,  // one credit back per high cycle
    output logic                  issue_valid_o,
    output id_pkg::issue_t        issue_o
);
    import id_pkg::*;

    logic [`ID_CNT_W-1:0] credit_cnt;   // execute slots still available
    logic                 has_credit;
    issue_t               issue_d;

    // decoded head drives the register file read ports directly
    assign rs1_addr_o = dec_i.rs1;
    assign rs2_addr_o = dec_i.rs2;

    assign has_credit = (credit_cnt != '0);
    assign pop_o      = not_empty_i && has_credit;

    // ==================================================
    // credit counter
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            credit_cnt <= `ID_CNT_W'(`ID_EX_CREDITS);   // full after reset
        end else begin
            credit_cnt <= credit_cnt + `ID_CNT_W'(ex_credit_i) - `ID_CNT_W'(pop_o);
        end
    end

    // ==================================================
    // issue register
    // ==================================================
    always_comb begin
        issue_d.dec     = dec_i;
        issue_d.pc      = head_i.pc;
        issue_d.rs1_val = rs1_data_i;   // includes writeback bypass
        issue_d.rs2_val = rs2_data_i;
    end

    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= pop_o;      // one cycle per issued word
        end
    end

    // payload held between issues
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            issue_o <= issue_d;
        end
    end

    // execute returning more credits than it was given
    a_cnt_max: assert property (@(posedge clk_i) disable iff (!resetn_i)
        credit_cnt <= `ID_CNT_W'(`ID_EX_CREDITS))
        else $error("id_issue_ctrl: credit counter overflow");

endmodule

// ==== id_stage.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module id_stage (
    input  logic               clk_i,
    input  logic               resetn_i,
    input  logic               fetch_valid_i,
    input  id_pkg::fetch_pkt_t fetch_i,
    output logic               fetch_credit_o,
    input  id_pkg::wb_t        wb_i,
    input  logic               ex_credit_i,
    output logic               issue_valid_o,
    output id_pkg::issue_t     issue_o
);
    import id_pkg::*;

    fetch_pkt_t            head;
    logic                  not_empty;
    logic                  pop;
    dec_t                  dec;
    logic [`ID_REG_AW-1:0] rs1_addr;
    logic [`ID_REG_AW-1:0] rs2_addr;
    logic [`ID_XLEN-1:0]   rs1_data;
    logic [`ID_XLEN-1:0]   rs2_data;

    // ==================================================
    // buffer -> decode -> read -> issue
    // ==================================================
    id_in_buffer u_in_buffer (
        .clk_i       (clk_i),
        .resetn_i    (resetn_i),
        .push_i      (fetch_valid_i),
        .push_data_i (fetch_i),
        .pop_i       (pop),
        .head_o      (head),
        .not_empty_o (not_empty),
        .credit_o    (fetch_credit_o)
    );

    instr_decoder u_decoder (
        .instr_i (head.instr),
        .dec_o   (dec)
    );

    regfile #(
        .REG_DATA_WIDTH     (`ID_XLEN),
        .REGFILE_ADDR_WIDTH (`ID_REG_AW),
        .REGFILE_DEPTH      (`ID_REG_NUM)
    ) u_regfile (
        .clk_i      (clk_i),
        .resetn_i   (resetn_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_i)
    );

    id_issue_ctrl u_issue_ctrl (
        .clk_i         (clk_i),
        .resetn_i      (resetn_i),
        .not_empty_i   (not_empty),
        .head_i        (head),
        .dec_i         (dec),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .pop_o         (pop),
        .ex_credit_i   (ex_credit_i),
        .issue_valid_o (issue_valid_o),
        .issue_o       (issue_o)
    );

endmodule

// ==== tb_id_stage.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module tb_id_stage;
    import id_pkg::*;

    localparam int MAX_CYCLES = 4000;  // traffic below needs roughly 1100 cycles
    localparam int N_RANDOM   = 300;
    localparam int N_BYPASS   = 16;
    localparam int N_BP       = 100;

    logic       clk_i;
    logic       resetn_i;
    logic       fetch_valid_i;
    fetch_pkt_t fetch_i;
    logic       fetch_credit_o;
    wb_t        wb_i;
    logic       ex_credit_i;
    logic       issue_valid_o;
    issue_t     issue_o;

    logic [`ID_XLEN-1:0] reg_model [`ID_REG_NUM];  // architectural view
    issue_t              exp_q [$];                // expected bundles in order
    int                  fetch_credits;            // sender side
    int                  stage_credits;            // execute credits the stage holds
    int                  hold_cycles;              // remaining credit stall
    bit                  bp_mode;
    int                  sent_total     = 0;
    int                  issued_total   = 0;
    int                  returned_total = 0;
    int                  cycle_cnt      = 0;
    logic [`ID_XLEN-1:0] pc_next;

    id_stage u_id_stage (
        .clk_i          (clk_i),
        .resetn_i       (resetn_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_i        (fetch_i),
        .fetch_credit_o (fetch_credit_o),
        .wb_i           (wb_i),
        .ex_credit_i    (ex_credit_i),
        .issue_valid_o  (issue_valid_o),
        .issue_o        (issue_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;   // 40 ns period
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // model takes writes at the edge and never writes x0
    always @(posedge clk_i) begin
        if (resetn_i && wb_i.we && wb_i.addr != '0) begin
            reg_model[wb_i.addr] <= wb_i.data;
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // ==================================================
    // reference decode and operand read
    // ==================================================
    function automatic logic [31:0] read_model(input logic [4:0] addr, input wb_t byp);
        if (addr == 5'd0) return 32'd0;
        if (byp.we && byp.addr == addr) return byp.data;   // same-cycle write wins
        return reg_model[addr];
    endfunction

    function automatic issue_t ref_issue(input fetch_pkt_t pkt, input wb_t byp);
        issue_t      r;
        logic [31:0] w;
        logic [3:0]  op;
        logic [2:0]  use_v;   // {reads rs1, reads rs2, writes rd}
        logic [31:0] imm;
        w     = pkt.instr;
        r     = '0;
        imm   = 32'd0;
        op    = 4'(OP_ILLEGAL);
        use_v = 3'b000;
        case (w[6:0])
            7'h33: {op, use_v} = {4'(OP_ALU_R), 3'b111};
            7'h13: begin
                {op, use_v} = {4'(OP_ALU_I), 3'b101};
                imm = {{20{w[31]}}, w[31:20]};
            end
            7'h03: begin
                {op, use_v} = {4'(OP_LOAD), 3'b101};
                imm = {{20{w[31]}}, w[31:20]};
            end
            7'h23: begin
                {op, use_v} = {4'(OP_STORE), 3'b110};
                imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            7'h63: begin
                {op, use_v} = {4'(OP_BRANCH), 3'b110};
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'h37: begin
                {op, use_v} = {4'(OP_LUI), 3'b001};
                imm = {w[31:12], 12'h000};
            end
            7'h17: begin
                {op, use_v} = {4'(OP_AUIPC), 3'b001};
                imm = {w[31:12], 12'h000};
            end
            7'h6f: begin
                {op, use_v} = {4'(OP_JAL), 3'b001};
                imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin
                {op, use_v} = {4'(OP_JALR), 3'b101};
                imm = {{20{w[31]}}, w[31:20]};
            end
            default: ;   // everything else illegal
        endcase
        r.dec.op        = id_op_e'(op);
        r.dec.rs1       = use_v[2] ? w[19:15] : 5'd0;
        r.dec.rs2       = use_v[1] ? w[24:20] : 5'd0;
        r.dec.rd        = use_v[0] ? w[11:7] : 5'd0;
        r.dec.rd_we     = use_v[0];
        r.dec.funct3    = w[14:12];
        r.dec.funct7_b5 = w[30];
        r.dec.imm       = imm;
        r.pc            = pkt.pc;
        r.rs1_val       = read_model(r.dec.rs1, byp);
        r.rs2_val       = read_model(r.dec.rs2, byp);
        return r;
    endfunction

    // ==================================================
    // compare process
    // ==================================================
    always @(negedge clk_i) begin : compare
        issue_t e;
        if (resetn_i && issue_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("issue seen at %0t with no word outstanding", $time);
                $display("TEST FAILED");
                $fatal(1, "unexpected issue");
            end else begin
                e = exp_q.pop_front();
                check_eq("op", 32'(issue_o.dec.op), 32'(e.dec.op));
                check_eq("rs1", 32'(issue_o.dec.rs1), 32'(e.dec.rs1));
                check_eq("rs2", 32'(issue_o.dec.rs2), 32'(e.dec.rs2));
                check_eq("rd", 32'(issue_o.dec.rd), 32'(e.dec.rd));
                check_eq("rd_we", 32'(issue_o.dec.rd_we), 32'(e.dec.rd_we));
                check_eq("funct3", 32'(issue_o.dec.funct3), 32'(e.dec.funct3));
                check_eq("funct7_b5", 32'(issue_o.dec.funct7_b5), 32'(e.dec.funct7_b5));
                check_eq("imm", issue_o.dec.imm, e.dec.imm);
                check_eq("pc", issue_o.pc, e.pc);   // order check too
                check_eq("rs1_val", issue_o.rs1_val, e.rs1_val);
                check_eq("rs2_val", issue_o.rs2_val, e.rs2_val);
                issued_total++;
            end
        end
    end

    // ==================================================
    // stimulus helpers
    // ==================================================
    // advance one falling edge and run the execute side
    task automatic next_cycle();
        @(negedge clk_i);
        if (fetch_credit_o) begin
            fetch_credits++;
            returned_total++;
        end
        stage_credits = stage_credits + int'(ex_credit_i) - int'(issue_valid_o);
        if (stage_credits < 0 || stage_credits > `ID_EX_CREDITS ||
            fetch_credits > `ID_IN_DEPTH) begin
            $display("credit count out of range at %0t: execute %0d fetch %0d",
                     $time, stage_credits, fetch_credits);
            $display("TEST FAILED");
            $fatal(1, "credit accounting broken");
        end
        fetch_valid_i = 1'b0;
        wb_i          = '0;
        if (bp_mode && hold_cycles == 0 && $urandom_range(3) == 0) begin
            hold_cycles = $urandom_range(12, 1);   // stall length
        end
        if (hold_cycles > 0) begin
            ex_credit_i = 1'b0;
            hold_cycles--;
        end else begin
            ex_credit_i = (stage_credits < `ID_EX_CREDITS);   // hand back what is owed
        end
    endtask

    function automatic fetch_pkt_t make_pkt(input logic [31:0] w);
        fetch_pkt_t p;
        p.instr = w;
        p.pc    = pc_next;
        pc_next = pc_next + 32'd4;
        return p;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = $urandom();
        case ($urandom_range(10))
            0:       w[6:0] = 7'h33;
            1:       w[6:0] = 7'h13;
            2:       w[6:0] = 7'h03;
            3:       w[6:0] = 7'h23;
            4:       w[6:0] = 7'h63;
            5:       w[6:0] = 7'h37;
            6:       w[6:0] = 7'h17;
            7:       w[6:0] = 7'h6f;
            8:       w[6:0] = 7'h67;
            9:       w[6:0] = 7'h73;   // system opcode decodes illegal
            default: ;                 // raw random opcode
        endcase
        return w;
    endfunction

    // waits for a fetch credit before sending
    task automatic send_word(input fetch_pkt_t pkt, input wb_t byp);
        next_cycle();
        while (fetch_credits == 0) next_cycle();
        fetch_valid_i = 1'b1;
        fetch_i       = pkt;
        fetch_credits--;
        sent_total++;
        exp_q.push_back(ref_issue(pkt, byp));
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        next_cycle();
        wb_i = {1'b1, addr, data};
    endtask

    // pipe empty and all execute credits back
    task automatic drain();
        next_cycle();
        while (exp_q.size() != 0 || stage_credits != `ID_EX_CREDITS) next_cycle();
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin : main
        fetch_pkt_t  pkt;
        wb_t         byp;
        logic [4:0]  ra;
        logic [4:0]  rb;
        void'($urandom(18366));
        resetn_i      = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_i       = '0;
        wb_i          = '0;
        ex_credit_i   = 1'b0;
        fetch_credits = `ID_IN_DEPTH;
        stage_credits = `ID_EX_CREDITS;
        hold_cycles   = 0;
        bp_mode       = 1'b0;
        pc_next       = 32'h0000_1000;
        for (int i = 0; i < `ID_REG_NUM; i++) begin
            reg_model[i] = '0;
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        resetn_i = 1'b1;

        // quiet after reset and every register reads zero
        repeat (5) begin
            next_cycle();
            check_eq("issue_valid_o", 32'(issue_valid_o), 32'd0);
            check_eq("fetch_credit_o", 32'(fetch_credit_o), 32'd0);
        end
        for (int i = 0; i < 32; i++) begin
            send_word(make_pkt({7'd0, 5'(31 - i), 5'(i), 3'd0, 5'(i), 7'h33}), '0);
        end
        drain();

        // x0 ignores writes while x5 keeps one
        write_reg(5'd0, 32'hdead_beef);
        write_reg(5'd5, 32'h1234_5678);
        send_word(make_pkt({7'd0, 5'd5, 5'd0, 3'd0, 5'd1, 7'h33}), '0);
        drain();

        // random words with registers rewritten between bursts
        for (int i = 0; i < N_RANDOM; i++) begin
            if (i % 20 == 0) begin
                drain();
                repeat (4) write_reg(5'($urandom_range(31)), $urandom());
            end
            send_word(make_pkt(rand_word()), '0);
        end
        drain();

        // writeback in the read cycle must bypass
        for (int i = 0; i < N_BYPASS; i++) begin
            drain();
            ra  = 5'($urandom_range(31, 1));
            rb  = 5'($urandom_range(31));
            byp = {1'b1, ($urandom_range(1) == 0) ? ra : rb, $urandom()};
            pkt = make_pkt({7'd0, rb, ra, 3'd0, 5'd3, 7'h33});
            send_word(pkt, byp);
            next_cycle();
            wb_i = byp;
        end
        drain();

        // execute withholds credits for random stretches
        bp_mode = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            send_word(make_pkt(rand_word()), '0);
        end
        drain();
        bp_mode = 1'b0;
        drain();

        check_eq("fetch credits returned", 32'(returned_total), 32'(issued_total));
        check_eq("words issued", 32'(issued_total), 32'(sent_total));
        check_eq("fetch credits held", 32'(fetch_credits), 32'(`ID_IN_DEPTH));
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
id_pkg.sv
id_in_buffer.sv
instr_decoder.sv
regfile.sv
id_issue_ctrl.sv
id_stage.sv
tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the id stage testbench with verilator, run it, then scan the log
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_id_stage \
    -o tb_id_stage > build.log 2>&1 \
    && ./obj_dir/tb_id_stage > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
